// ==== port_pkg.sv ====
`default_nettype none

package port_pkg;

    // the one-hot source map fills a fixed 4-bit field of the forward descriptor.
    localparam int num_ports = 4;

    typedef logic [1:0] port_idx_t;

    typedef logic [num_ports-1:0] portmap_t;

    // one received byte from the MAC.
    typedef struct packed {
        logic       valid;
        logic       last;
        logic       err;    // bad FCS, only meaningful on the last byte.
        logic [7:0] data;
    } rx_beat_t;

endpackage

`default_nettype wire

// ==== frame_pkg.sv ====
`default_nettype none

package frame_pkg;

    // frame limits count the FCS.
    localparam int min_frame = 64;
    localparam int max_frame = 1518;
    localparam int fcs_len   = 4;

    // descriptor as written by a port buffer.
    typedef struct packed {
        logic        fcs_err;
        logic        len_err;
        logic        spare;
        logic [12:0] len;      // byte count including the FCS.
    } rx_desc_t;

    // descriptor as handed to the forwarding side.
    typedef struct packed {
        logic                 zero;
        port_pkg::portmap_t   src_map;
        logic [10:0]          len;      // byte count with the FCS removed.
    } fwd_desc_t;

    // same word, decoded one way before the mux and another way after it.
    typedef union packed {
        rx_desc_t  rx;
        fwd_desc_t fwd;
    } desc_word_u;

endpackage

`default_nettype wire

// ==== sync_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 16
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         wr,
    input  logic [width-1:0]             din,
    input  logic                         rd,
    output logic [width-1:0]             dout,
    output logic                         full,
    output logic                         empty,
    output logic [$clog2(depth+1)-1:0]   count
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;
    localparam int cw = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [aw-1:0]    wr_ptr;
    logic [aw-1:0]    rd_ptr;

    // depth need not be a power of two, so the pointers wrap explicitly.
    function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
        return (ptr == aw'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr)
                wr_ptr <= next_ptr(wr_ptr);
            if (rd)
                rd_ptr <= next_ptr(rd_ptr);
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr)
            mem[wr_ptr] <= din;
        if (rd)
            dout <= mem[rd_ptr];    // head shows one cycle after the strobe and holds.
    end

    assign full  = (count == cw'(depth));
    assign empty = (count == '0);

    assert property (@(posedge clk) disable iff (!rstn) wr |-> !full)
        else $error("sync_fifo: write while full");
    assert property (@(posedge clk) disable iff (!rstn) rd |-> !empty)
        else $error("sync_fifo: read while empty");

endmodule

`default_nettype wire

// ==== rx_port_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module rx_port_buffer #(
    parameter int port_data_depth = 2048,
    parameter int port_desc_depth = 32
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  port_pkg::rx_beat_t    beat,
    input  logic                  data_rd,
    output logic [7:0]            data_dout,
    input  logic                  desc_rd,
    output frame_pkg::desc_word_u desc_dout,
    output logic                  desc_empty
);

    import frame_pkg::*;

    logic [12:0] byte_cnt;
    logic [12:0] frame_len;
    logic        len_bad;
    desc_word_u  desc_new;
    logic        data_full;
    logic        desc_full;

    assign frame_len = byte_cnt + 13'd1;    // length including the current byte.

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            byte_cnt <= '0;
        end else if (beat.valid) begin
            byte_cnt <= beat.last ? '0 : frame_len;
        end
    end

    assign len_bad = (frame_len < 13'(min_frame)) || (frame_len > 13'(max_frame));

    // the descriptor goes in on the same edge as the last byte.
    assign desc_new.rx = '{fcs_err: beat.err, len_err: len_bad, spare: 1'b0, len: frame_len};

    sync_fifo #(
        .width(8),
        .depth(port_data_depth)
    ) u_data_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (beat.valid),
        .din   (beat.data),
        .rd    (data_rd),
        .dout  (data_dout),
        .full  (data_full),
        .empty (),
        .count ()
    );

    sync_fifo #(
        .width(16),
        .depth(port_desc_depth)
    ) u_desc_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (beat.valid && beat.last),
        .din   (desc_new),
        .rd    (desc_rd),
        .dout  (desc_dout),
        .full  (desc_full),
        .empty (desc_empty),
        .count ()
    );

    // the MAC cannot be stalled, so the sender has to respect buffer capacity.
    assert property (@(posedge clk) disable iff (!rstn)
        beat.valid |-> !data_full && !(beat.last && desc_full))
        else $error("rx_port_buffer: beat arrived with no room in the buffer");

endmodule

`default_nettype wire

// ==== interface_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

module interface_mux #(
    parameter int data_depth = 4096,
    parameter int desc_depth = 32
) (
    input  logic                                        clk,
    input  logic                                        rstn,
    output logic [port_pkg::num_ports-1:0]              data_rd,
    input  logic [port_pkg::num_ports-1:0][7:0]         data_dout,
    output logic [port_pkg::num_ports-1:0]              desc_rd,
    input  frame_pkg::desc_word_u [port_pkg::num_ports-1:0] desc_dout,
    input  logic [port_pkg::num_ports-1:0]              desc_empty,
    input  logic                                        frame_rd,
    output logic [7:0]                                  frame_data,
    input  logic                                        desc_rd_out,
    output frame_pkg::desc_word_u                       desc,
    output logic                                        desc_empty_out
);

    import port_pkg::*;
    import frame_pkg::*;

    localparam int cnt_w = $clog2(data_depth + 1);

    localparam logic [2:0] st_idle   = 3'd0;
    localparam logic [2:0] st_desc   = 3'd1;
    localparam logic [2:0] st_load   = 3'd2;
    localparam logic [2:0] st_first  = 3'd3;
    localparam logic [2:0] st_stream = 3'd4;
    localparam logic [2:0] st_tail   = 3'd5;
    localparam logic [2:0] st_build  = 3'd6;
    localparam logic [2:0] st_write  = 3'd7;

    logic [2:0]       state;
    port_idx_t        rr;
    port_idx_t        sel;
    port_idx_t        pick;
    port_idx_t        idx;
    logic             found;
    portmap_t         sel_map;
    logic [12:0]      cnt;
    logic             error;
    logic             desc_rd_q;
    logic             data_rd_q;
    logic             fifo_wr;
    logic [7:0]       fifo_din;
    logic             desc_wr;
    desc_word_u       desc_din;
    desc_word_u       cur_desc;
    logic [7:0]       cur_byte;
    logic [cnt_w-1:0] data_count;
    logic             desc_full;
    logic             bp;

    assign cur_desc = desc_dout[sel];
    assign cur_byte = data_dout[sel];
    assign sel_map  = portmap_t'(1) << sel;

    // strobes only reach the selected port.
    assign desc_rd = desc_rd_q ? sel_map : '0;
    assign data_rd = data_rd_q ? sel_map : '0;

    // leave room for a whole maximum frame before starting one.
    assign bp = (int'(data_count) > data_depth - max_frame) || desc_full;

    // first port with a complete frame, searching from the pointer.
    always_comb begin
        found = 1'b0;
        pick  = rr;
        idx   = rr;
        for (int i = 0; i < num_ports; i++) begin
            idx = rr + port_idx_t'(i);
            if (!found && !desc_empty[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= st_idle;
            rr        <= '0;
            sel       <= '0;
            cnt       <= '0;
            error     <= 1'b0;
            desc_rd_q <= 1'b0;
            data_rd_q <= 1'b0;
            fifo_wr   <= 1'b0;
            desc_wr   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (!bp && found) begin
                        sel       <= pick;
                        rr        <= pick + 1'b1;   // next search starts past the winner.
                        desc_rd_q <= 1'b1;
                        state     <= st_desc;
                    end
                end
                st_desc: begin
                    desc_rd_q <= 1'b0;
                    state     <= st_load;
                end
                st_load: begin
                    cnt       <= cur_desc.rx.len;
                    error     <= cur_desc.rx.fcs_err | cur_desc.rx.len_err;
                    data_rd_q <= 1'b1;
                    state     <= st_first;
                end
                st_first: begin
                    if (cnt == 13'd1) begin
                        cnt       <= '0;
                        data_rd_q <= 1'b0;
                        state     <= st_tail;
                    end else begin
                        cnt   <= cnt - 13'd1;
                        state <= st_stream;
                    end
                end
                st_stream: begin
                    if (cnt > 13'd1) begin
                        cnt <= cnt - 13'd1;
                    end else begin
                        cnt       <= '0;
                        data_rd_q <= 1'b0;
                        state     <= st_tail;
                    end
                    // the last four bytes on dout are the FCS.
                    fifo_wr <= !error && (cnt > 13'd3);
                end
                st_tail: begin
                    state <= st_build;    // final byte is drained here.
                end
                st_build: begin
                    desc_wr <= !error;
                    state   <= st_write;
                end
                st_write: begin
                    desc_wr <= 1'b0;
                    state   <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        fifo_din <= cur_byte;
        if (state == st_build)
            desc_din.fwd <= '{zero: 1'b0, src_map: sel_map,
                              len: cur_desc.rx.len[10:0] - 11'(fcs_len)};
    end

    sync_fifo #(
        .width(8),
        .depth(data_depth)
    ) u_data_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (fifo_wr),
        .din   (fifo_din),
        .rd    (frame_rd),
        .dout  (frame_data),
        .full  (),
        .empty (),
        .count (data_count)
    );

    sync_fifo #(
        .width(16),
        .depth(desc_depth)
    ) u_desc_fifo (
        .clk   (clk),
        .rstn  (rstn),
        .wr    (desc_wr),
        .din   (desc_din),
        .rd    (desc_rd_out),
        .dout  (desc),
        .full  (desc_full),
        .empty (desc_empty_out),
        .count ()
    );

    // the grant was taken a cycle earlier, so the port must still hold that frame.
    assert property (@(posedge clk) disable iff (!rstn) |desc_rd |-> !desc_empty[sel])
        else $error("interface_mux: descriptor read from an empty port");

endmodule

`default_nettype wire

// ==== ingress_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ingress_top #(
    parameter int port_data_depth = 2048,
    parameter int port_desc_depth = 32,
    parameter int data_depth      = 4096,
    parameter int desc_depth      = 32
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  port_pkg::rx_beat_t [port_pkg::num_ports-1:0] rx_beat,
    input  logic                                      frame_rd,
    output logic [7:0]                                frame_data,
    input  logic                                      desc_rd,
    output frame_pkg::desc_word_u                     desc,
    output logic                                      desc_empty
);

    import port_pkg::*;
    import frame_pkg::*;

    logic [num_ports-1:0]      port_data_rd;
    logic [num_ports-1:0][7:0] port_data_dout;
    logic [num_ports-1:0]      port_desc_rd;
    desc_word_u [num_ports-1:0] port_desc_dout;
    logic [num_ports-1:0]      port_desc_empty;

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        rx_port_buffer #(
            .port_data_depth(port_data_depth),
            .port_desc_depth(port_desc_depth)
        ) u_rx_buf (
            .clk        (clk),
            .rstn       (rstn),
            .beat       (rx_beat[p]),
            .data_rd    (port_data_rd[p]),
            .data_dout  (port_data_dout[p]),
            .desc_rd    (port_desc_rd[p]),
            .desc_dout  (port_desc_dout[p]),
            .desc_empty (port_desc_empty[p])
        );
    end

    interface_mux #(
        .data_depth(data_depth),
        .desc_depth(desc_depth)
    ) u_mux (
        .clk            (clk),
        .rstn           (rstn),
        .data_rd        (port_data_rd),
        .data_dout      (port_data_dout),
        .desc_rd        (port_desc_rd),
        .desc_dout      (port_desc_dout),
        .desc_empty     (port_desc_empty),
        .frame_rd       (frame_rd),
        .frame_data     (frame_data),
        .desc_rd_out    (desc_rd),
        .desc           (desc),
        .desc_empty_out (desc_empty)
    );

endmodule

`default_nettype wire

// ==== tb_ingress_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ingress_top;

    import port_pkg::*;
    import frame_pkg::*;

    localparam int wait_limit = 5000;

    logic                     clk;
    logic                     rstn;
    rx_beat_t [num_ports-1:0] rx_beat;
    logic                     frame_rd;
    logic [7:0]               frame_data;
    logic                     desc_rd;
    desc_word_u               desc;
    logic                     desc_empty;

    logic [31:0] rng;
    int          mismatches;
    int          failures;
    int          expected_frames;
    logic        timed_out;
    int          exp_len [num_ports][$];    // kept lengths per port, in send order.
    logic [7:0]  exp_bytes [num_ports][$];

    ingress_top DUT (
        .clk        (clk),
        .rstn       (rstn),
        .rx_beat    (rx_beat),
        .frame_rd   (frame_rd),
        .frame_data (frame_data),
        .desc_rd    (desc_rd),
        .desc       (desc),
        .desc_empty (desc_empty)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic check_equal(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // drives one frame into a port and records what the mux should forward.
    task automatic send_frame(input port_idx_t port, input int length, input logic bad_fcs);
        logic       keep;
        logic [7:0] b;
        keep = !bad_fcs && length >= min_frame && length <= max_frame;
        if (keep) begin
            exp_len[port].push_back(length - fcs_len);
            expected_frames++;
        end
        for (int i = 0; i < length; i++) begin
            @(posedge clk);
            #2;
            rng = next_random(rng);
            b   = rng[7:0];
            rx_beat[port] = '{valid: 1'b1, last: i == length - 1,
                              err: bad_fcs && i == length - 1, data: b};
            if (keep && i < length - fcs_len)
                exp_bytes[port].push_back(b);
        end
        @(posedge clk);
        #2;
        rx_beat[port] = '0;
    endtask

    // pops one descriptor and its bytes and checks them against the port's queue.
    task automatic read_frame(output port_idx_t port);
        int         waited;
        int         dut_len;
        int         exp;
        logic [7:0] exp_byte;
        portmap_t   map;
        port   = '0;
        waited = 0;
        if (timed_out)
            return;
        @(posedge clk);
        #2;
        while (desc_empty && waited < wait_limit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (desc_empty) begin
            $display("Timeout: no descriptor arrived within %0d cycles at %0t", wait_limit, $time);
            failures++;
            timed_out = 1'b1;
            return;
        end
        desc_rd = 1'b1;
        @(posedge clk);
        #2;
        desc_rd = 1'b0;
        map     = desc.fwd.src_map;
        dut_len = int'(desc.fwd.len);
        check_equal("descriptor zero bit", int'(desc.fwd.zero), 0);
        assert ($onehot(map)) else begin
            $display("Descriptor at %0t has a source map that is not one-hot", $time);
            failures++;
        end
        for (int p = 0; p < num_ports; p++)
            if (map == portmap_t'(1 << p))
                port = port_idx_t'(p);
        exp = 0;
        if (exp_len[port].size() == 0) begin
            $display("Descriptor from port %0d at %0t was never expected", port, $time);
            failures++;
        end else begin
            exp = exp_len[port].pop_front();
            expected_frames--;
            check_equal($sformatf("port %0d frame length", port), dut_len, exp);
        end
        // byte i shows on frame_data one cycle after its read strobe.
        for (int i = 0; i <= dut_len; i++) begin
            if (i > 0 && i <= exp) begin
                exp_byte = exp_bytes[port].pop_front();
                check_equal($sformatf("port %0d byte %0d", port, i - 1),
                            int'(frame_data), int'(exp_byte));
            end
            frame_rd = i < dut_len;
            @(posedge clk);
            #2;
        end
        for (int i = dut_len; i < exp; i++)
            void'(exp_bytes[port].pop_front());
    endtask

    task automatic load_all_ports(input int length);
        fork
            send_frame(2'd0, length, 1'b0);
            send_frame(2'd1, length, 1'b0);
            send_frame(2'd2, length, 1'b0);
            send_frame(2'd3, length, 1'b0);
        join
    endtask

    task automatic forward_single_frame();
        port_idx_t port;
        send_frame(2'd1, 100, 1'b0);
        read_frame(port);
        check_equal("single frame source port", int'(port), 1);
    endtask

    task automatic drop_bad_frames();
        port_idx_t port;
        send_frame(2'd0, 90, 1'b1);
        send_frame(2'd0, 40, 1'b0);    // runt.
        send_frame(2'd0, 120, 1'b0);
        read_frame(port);
        check_equal("source port after dropped frames", int'(port), 0);
        idle_cycles(300);
        assert (desc_empty) else begin
            $display("A dropped frame left a descriptor behind at %0t", $time);
            failures++;
        end
    endtask

    task automatic rotate_grants();
        port_idx_t port;
        port_idx_t ptr;
        port_idx_t exp_port;
        send_frame(2'd2, 70, 1'b0);
        read_frame(port);
        ptr = 2'd3;    // the search restarts just past the last grant.
        for (int round = 0; round < 2; round++) begin
            load_all_ports(80);
            for (int k = 0; k < num_ports; k++) begin
                exp_port = ptr + port_idx_t'(k);
                read_frame(port);
                check_equal("grant order", int'(port), int'(exp_port));
            end
            ptr = exp_port + 2'd1;
        end
    endtask

    task automatic drain_after_backpressure();
        port_idx_t port;
        // sixteen frames keep 4736 bytes and overflow the shared FIFO unless the mux stalls.
        for (int n = 0; n < 16; n++)
            send_frame(port_idx_t'(n), 300, 1'b0);
        idle_cycles(500);
        while (expected_frames > 0 && !timed_out)
            read_frame(port);
    endtask

    task automatic random_traffic();
        port_idx_t   port;
        logic [31:0] r;
        for (int n = 0; n < 16; n++) begin
            rng = next_random(rng);
            r   = rng;
            send_frame(port_idx_t'(r[1:0]), 40 + int'(r[15:8]), r[23:20] == 4'd0);
        end
        while (expected_frames > 0 && !timed_out)
            read_frame(port);
        idle_cycles(200);
        assert (desc_empty) else begin
            $display("A leftover descriptor was found at %0t", $time);
            failures++;
        end
    endtask

    initial begin
        rstn            = 1'b0;
        rx_beat         = '0;
        frame_rd        = 1'b0;
        desc_rd         = 1'b0;
        rng             = 32'hd90e;
        mismatches      = 0;
        failures        = 0;
        expected_frames = 0;
        timed_out       = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;
        check_equal("desc_empty after reset", int'(desc_empty), 1);
        forward_single_frame();
        drop_bad_frames();
        rotate_grants();
        drain_after_backpressure();
        random_traffic();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ingress_top.f ====
port_pkg.sv
frame_pkg.sv
sync_fifo.sv
rx_port_buffer.sv
interface_mux.sv
ingress_top.sv
tb_ingress_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ingress_top -f ingress_top.f \
    -o sim_ingress && ./obj_dir/sim_ingress > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log 2>/dev/null && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
